// File: logic/dm_gate_pkg.sv
// Shared widths, multibit encodings and enable slot indices, sized for a fixed hart count of two
package dm_gate_pkg;

  ////////////////////////////////////////
  // Widths and multibit encodings
  ////////////////////////////////////////

  // CSR data word
  typedef logic [31:0] word_t;

  // Life cycle multibit enable, one bit per lane
  localparam int LcTxWidth = 4;
  typedef logic [LcTxWidth-1:0] lc_tx_t;
  localparam lc_tx_t LcTxOn  = 4'b1010;
  localparam lc_tx_t LcTxOff = 4'b0101;

  // OTP multibit value
  typedef logic [7:0] mubi8_t;
  localparam mubi8_t MuBi8True  = 8'h96;
  localparam mubi8_t MuBi8False = 8'h69;

  // CSR multibit value, the false pattern doubles as reset value
  typedef logic [31:0] mubi32_t;
  localparam mubi32_t MuBi32True  = 32'h96969696;
  localparam mubi32_t MuBi32False = 32'h69696969;

  ////////////////////////////////////////
  // Harts and gated functions
  ////////////////////////////////////////

  localparam int NumHarts = 2;
  typedef logic [NumHarts-1:0] hart_vec_t;

  // Flop depth of every synchronizer
  localparam int SyncStages = 2;

  // Debug request slots start right after the three bus functions
  localparam int LcEnDebugReqVal = 3;
  localparam int LcEnResetReqVal = LcEnDebugReqVal + NumHarts;
  // Room for the reset slot plus the count that follows it
  localparam int LcEnIdxWidth    = $clog2(LcEnResetReqVal + 2);

  // One slot per gated function, debug requests take NumHarts slots
  typedef enum logic [LcEnIdxWidth-1:0] {
    LcEnFetch,
    LcEnRom,
    LcEnSba,
    LcEnDebugReq,
    LcEnResetReq = LcEnIdxWidth'(LcEnResetReqVal),
    LcEnLastPos
  } lc_en_e;

endpackage

// File: logic/dm_late_debug_regs.sv
// Write strobe must already be address decoded and only the exact MuBi32True word enables late debug
`timescale 1ns/1ps

module dm_late_debug_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Qualified write strobe and data
  input  logic                reg_we_i,
  input  dm_gate_pkg::word_t  reg_wdata_i,
  // Read-back of the stored word
  output dm_gate_pkg::word_t  reg_rdata_o,
  // Decoded late debug enable
  output logic                late_debug_en_o
);

  ////////////////////////////////////////
  // Late debug enable CSR
  ////////////////////////////////////////

  dm_gate_pkg::mubi32_t late_debug_q;

  // Starts disabled, loads the full word on every strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      late_debug_q <= dm_gate_pkg::MuBi32False;
    end else if (reg_we_i) begin
      late_debug_q <= dm_gate_pkg::mubi32_t'(reg_wdata_i);
    end
  end

  // Software sees exactly what it wrote, invalid patterns included
  assign reg_rdata_o = dm_gate_pkg::word_t'(late_debug_q);

  ////////////////////////////////////////
  // Strict decode
  ////////////////////////////////////////

  // Any pattern other than the true encoding counts as disabled
  assign late_debug_en_o = (late_debug_q == dm_gate_pkg::MuBi32True);

endmodule

// File: logic/dm_lc_enable.sv
// Inputs are treated as asynchronous and enables lag any input change by SyncStages clock edges
`timescale 1ns/1ps

module dm_lc_enable (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Life cycle and OTP controls, from other clock domains
  input  dm_gate_pkg::lc_tx_t    lc_hw_debug_en_i,
  input  dm_gate_pkg::lc_tx_t    lc_dft_en_i,
  input  dm_gate_pkg::mubi8_t    otp_dis_late_debug_i,
  // From the late debug CSR, already in this domain
  input  logic                   late_debug_en_i,
  // Per-function enables
  output logic                   fetch_en_o,
  output logic                   rom_en_o,
  output logic                   sba_en_o,
  output dm_gate_pkg::hart_vec_t debug_req_en_o,
  output logic                   reset_req_en_o
);

  ////////////////////////////////////////
  // Input synchronizers
  ////////////////////////////////////////

  dm_gate_pkg::lc_tx_t hw_debug_sync_q [dm_gate_pkg::SyncStages];
  dm_gate_pkg::lc_tx_t dft_sync_q      [dm_gate_pkg::SyncStages];
  dm_gate_pkg::mubi8_t otp_dis_sync_q  [dm_gate_pkg::SyncStages];

  // Reset values all decode as disabled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < dm_gate_pkg::SyncStages; i++) begin
        hw_debug_sync_q[i] <= dm_gate_pkg::LcTxOff;
        dft_sync_q[i]      <= dm_gate_pkg::LcTxOff;
        otp_dis_sync_q[i]  <= dm_gate_pkg::MuBi8False;
      end
    end else begin
      hw_debug_sync_q[0] <= lc_hw_debug_en_i;
      dft_sync_q[0]      <= lc_dft_en_i;
      otp_dis_sync_q[0]  <= otp_dis_late_debug_i;
      // Shift towards the last stage
      for (int i = 1; i < dm_gate_pkg::SyncStages; i++) begin
        hw_debug_sync_q[i] <= hw_debug_sync_q[i-1];
        dft_sync_q[i]      <= dft_sync_q[i-1];
        otp_dis_sync_q[i]  <= otp_dis_sync_q[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // Hardened per-lane mux
  ////////////////////////////////////////

  dm_gate_pkg::lc_tx_t debug_en_gated;

  // Each lane owns its select comparator so one fault flips one lane only
  for (genvar k = 0; k < dm_gate_pkg::LcTxWidth; k++) begin : gen_lane_mux
    logic lane_sel;
    assign lane_sel = (otp_dis_sync_q[dm_gate_pkg::SyncStages-1] == dm_gate_pkg::MuBi8True) ||
                      late_debug_en_i;
    // Debug enable when late debug is allowed, DFT enable otherwise
    assign debug_en_gated[k] = lane_sel ? hw_debug_sync_q[dm_gate_pkg::SyncStages-1][k] :
                                          dft_sync_q[dm_gate_pkg::SyncStages-1][k];
  end

  ////////////////////////////////////////
  // Strict decode per function
  ////////////////////////////////////////

  logic [int'(dm_gate_pkg::LcEnLastPos)-1:0] func_en;

  // Separate comparator per slot, only LcTxOn enables
  for (genvar s = 0; s < int'(dm_gate_pkg::LcEnLastPos); s++) begin : gen_func_en
    assign func_en[s] = (debug_en_gated == dm_gate_pkg::LcTxOn);
  end

  assign fetch_en_o     = func_en[int'(dm_gate_pkg::LcEnFetch)];
  assign rom_en_o       = func_en[int'(dm_gate_pkg::LcEnRom)];
  assign sba_en_o       = func_en[int'(dm_gate_pkg::LcEnSba)];
  assign reset_req_en_o = func_en[int'(dm_gate_pkg::LcEnResetReq)];

  // Hart slots follow LcEnDebugReq back to back
  for (genvar h = 0; h < dm_gate_pkg::NumHarts; h++) begin : gen_hart_en
    assign debug_req_en_o[h] = func_en[int'(dm_gate_pkg::LcEnDebugReq) + h];
  end

endmodule

// File: logic/dm_ndm_reset_tracker.sv
// rst_lc_ni may be asynchronous to clk_i and the request must stay high until the life cycle reset is seen
`timescale 1ns/1ps

module dm_ndm_reset_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  // Life cycle reset of the rest of the system
  input  logic rst_lc_ni,
  // Raw NDM reset request, not gated
  input  logic ndmreset_req_i,
  // Reset request path enabled by life cycle
  input  logic reset_req_en_i,
  // One-cycle pulse once a full reset cycle has completed
  output logic ndmreset_ack_o
);

  ////////////////////////////////////////
  // Life cycle reset detection
  ////////////////////////////////////////

  logic [dm_gate_pkg::SyncStages-1:0] lc_rst_async_q;
  logic [dm_gate_pkg::SyncStages-1:0] lc_rst_sync_q;
  logic                               lc_rst_asserted;

  // Forced to ones while rst_lc_ni is low, drains to zero after release
  always_ff @(posedge clk_i or negedge rst_lc_ni) begin
    if (!rst_lc_ni) begin
      lc_rst_async_q <= '1;
    end else begin
      lc_rst_async_q <= {lc_rst_async_q[dm_gate_pkg::SyncStages-2:0], 1'b0};
    end
  end

  // Output of the first stage can go metastable on reset assertion
  // so it is resampled in our own reset domain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lc_rst_sync_q <= '0;
    end else begin
      lc_rst_sync_q <= {lc_rst_sync_q[dm_gate_pkg::SyncStages-2:0],
                        lc_rst_async_q[dm_gate_pkg::SyncStages-1]};
    end
  end

  assign lc_rst_asserted = lc_rst_sync_q[dm_gate_pkg::SyncStages-1];

  ////////////////////////////////////////
  // Pending flags
  ////////////////////////////////////////

  logic ndmreset_pending_q;
  logic lc_rst_pending_q;
  logic ndmreset_ack;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ndmreset_pending_q <= 1'b0;
      lc_rst_pending_q   <= 1'b0;
    end else begin
      // Latch a new request only when none is outstanding
      if (ndmreset_req_i && !ndmreset_pending_q) begin
        ndmreset_pending_q <= 1'b1;
      end else if (ndmreset_ack && ndmreset_pending_q) begin
        ndmreset_pending_q <= 1'b0;
      end
      // Only life cycle resets seen during a pending request count
      if (ndmreset_pending_q && lc_rst_asserted) begin
        lc_rst_pending_q <= 1'b1;
      end else if (ndmreset_ack && lc_rst_pending_q) begin
        lc_rst_pending_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Acknowledge
  ////////////////////////////////////////

  // Request seen, reset seen, both released, path still enabled
  // Flags clear on the next edge so the ack lasts one cycle
  assign ndmreset_ack = ndmreset_pending_q &&
                        lc_rst_pending_q &&
                        !ndmreset_req_i &&
                        !lc_rst_asserted &&
                        reset_req_en_i;

  assign ndmreset_ack_o = ndmreset_ack;

endmodule

// File: logic/dm_gate_top.sv
// Debug module core is external and its requests are gated here by life cycle enables without flush
`timescale 1ns/1ps

module dm_gate_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Life cycle reset of the rest of the system
  input  logic                   rst_lc_ni,
  // Life cycle and OTP controls
  input  dm_gate_pkg::lc_tx_t    lc_hw_debug_en_i,
  input  dm_gate_pkg::lc_tx_t    lc_dft_en_i,
  input  dm_gate_pkg::mubi8_t    otp_dis_late_debug_i,
  // Late debug CSR access
  input  logic                   reg_we_i,
  input  dm_gate_pkg::word_t     reg_wdata_i,
  output dm_gate_pkg::word_t     reg_rdata_o,
  // Requests from the debug module core
  input  logic                   ndmreset_req_i,
  input  dm_gate_pkg::hart_vec_t debug_req_i,
  // Gated function enables
  output logic                   fetch_en_o,
  output logic                   rom_en_o,
  output logic                   sba_en_o,
  // Gated requests and NDM reset acknowledge
  output dm_gate_pkg::hart_vec_t debug_req_o,
  output logic                   ndmreset_req_o,
  output logic                   ndmreset_ack_o
);

  logic                   late_debug_en;
  dm_gate_pkg::hart_vec_t debug_req_en;
  logic                   reset_req_en;

  ////////////////////////////////////////
  // CSR and enable logic
  ////////////////////////////////////////

  dm_late_debug_regs i_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reg_we_i        (reg_we_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rdata_o     (reg_rdata_o),
    .late_debug_en_o (late_debug_en)
  );

  dm_lc_enable i_lc_enable (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .lc_hw_debug_en_i     (lc_hw_debug_en_i),
    .lc_dft_en_i          (lc_dft_en_i),
    .otp_dis_late_debug_i (otp_dis_late_debug_i),
    .late_debug_en_i      (late_debug_en),
    .fetch_en_o           (fetch_en_o),
    .rom_en_o             (rom_en_o),
    .sba_en_o             (sba_en_o),
    .debug_req_en_o       (debug_req_en),
    .reset_req_en_o       (reset_req_en)
  );

  // Requests pass straight through once enabled
  assign debug_req_o    = debug_req_i & debug_req_en;
  assign ndmreset_req_o = ndmreset_req_i & reset_req_en;

  ////////////////////////////////////////
  // NDM reset tracking
  ////////////////////////////////////////

  // Tracker watches the raw request, gating only blocks the ack
  dm_ndm_reset_tracker i_ndm_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rst_lc_ni      (rst_lc_ni),
    .ndmreset_req_i (ndmreset_req_i),
    .reset_req_en_i (reset_req_en),
    .ndmreset_ack_o (ndmreset_ack_o)
  );

endmodule

// File: testbench/tb_dm_gate.sv
// Must run from the project root so the golden file path resolves, and expects two harts
`timescale 1ns/1ps

module tb_dm_gate;

  localparam int MaxLines    = 256;
  localparam int MaxHold     = 64;
  localparam int ResetCycles = 8;
  localparam int WatchdogNs  = 100000;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   rst_lc_ni;
  dm_gate_pkg::lc_tx_t    lc_hw_debug_en_i;
  dm_gate_pkg::lc_tx_t    lc_dft_en_i;
  dm_gate_pkg::mubi8_t    otp_dis_late_debug_i;
  logic                   reg_we_i;
  dm_gate_pkg::word_t     reg_wdata_i;
  dm_gate_pkg::word_t     reg_rdata_o;
  logic                   ndmreset_req_i;
  dm_gate_pkg::hart_vec_t debug_req_i;
  logic                   fetch_en_o;
  logic                   rom_en_o;
  logic                   sba_en_o;
  dm_gate_pkg::hart_vec_t debug_req_o;
  logic                   ndmreset_req_o;
  logic                   ndmreset_ack_o;

  int value_errors;
  int other_errors;
  int steps_run;

  // Stimulus fields of the current golden line
  logic [31:0] f_we, f_wdata, f_hw, f_dft, f_otp, f_req, f_dbg, f_lc, f_hold;
  // Expected outputs of the current golden line
  logic [31:0] e_fetch, e_rom, e_sba, e_dbg, e_ndm, e_rdata, e_ack;

  dm_gate_top i_dm_gate_top (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .rst_lc_ni            (rst_lc_ni),
    .lc_hw_debug_en_i     (lc_hw_debug_en_i),
    .lc_dft_en_i          (lc_dft_en_i),
    .otp_dis_late_debug_i (otp_dis_late_debug_i),
    .reg_we_i             (reg_we_i),
    .reg_wdata_i          (reg_wdata_i),
    .reg_rdata_o          (reg_rdata_o),
    .ndmreset_req_i       (ndmreset_req_i),
    .debug_req_i          (debug_req_i),
    .fetch_en_o           (fetch_en_o),
    .rom_en_o             (rom_en_o),
    .sba_en_o             (sba_en_o),
    .debug_req_o          (debug_req_o),
    .ndmreset_req_o       (ndmreset_req_o),
    .ndmreset_ack_o       (ndmreset_ack_o)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    #WatchdogNs;
    $display("Simulation did not finish within %0d ns", WatchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Checks and stepping
  ////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t step %0d %s expected %h got %h", $time, steps_run, name, exp, got);
    end
  endtask

  // Reset values hold even while the inputs ask for every function
  task automatic check_reset_outputs();
    compare_value("fetch_en_o", 32'(fetch_en_o), 32'd0);
    compare_value("rom_en_o", 32'(rom_en_o), 32'd0);
    compare_value("sba_en_o", 32'(sba_en_o), 32'd0);
    compare_value("debug_req_o", 32'(debug_req_o), 32'd0);
    compare_value("ndmreset_req_o", 32'(ndmreset_req_o), 32'd0);
    compare_value("reg_rdata_o", reg_rdata_o, dm_gate_pkg::MuBi32False);
    compare_value("ndmreset_ack_o", 32'(ndmreset_ack_o), 32'd0);
  endtask

  // Inputs change on falling edges and outputs are sampled 2 ns later
  task automatic run_step();
    int ack_count;
    ack_count = 0;
    steps_run++;
    for (int cyc = 0; cyc < int'(f_hold); cyc++) begin
      @(negedge clk_i);
      if (cyc == 0) begin
        reg_we_i             = f_we[0];
        reg_wdata_i          = f_wdata;
        lc_hw_debug_en_i     = dm_gate_pkg::lc_tx_t'(f_hw);
        lc_dft_en_i          = dm_gate_pkg::lc_tx_t'(f_dft);
        otp_dis_late_debug_i = dm_gate_pkg::mubi8_t'(f_otp);
        ndmreset_req_i       = f_req[0];
        debug_req_i          = dm_gate_pkg::hart_vec_t'(f_dbg);
      end else begin
        // Write strobe lasts one cycle
        reg_we_i = 1'b0;
      end
      // Life cycle reset pulse from the start of the step
      rst_lc_ni = (cyc < int'(f_lc)) ? 1'b0 : 1'b1;
      #2;
      if (ndmreset_ack_o) ack_count++;
    end
    // Levels on the last cycle of the step
    compare_value("fetch_en_o", 32'(fetch_en_o), e_fetch);
    compare_value("rom_en_o", 32'(rom_en_o), e_rom);
    compare_value("sba_en_o", 32'(sba_en_o), e_sba);
    compare_value("debug_req_o", 32'(debug_req_o), e_dbg);
    compare_value("ndmreset_req_o", 32'(ndmreset_req_o), e_ndm);
    compare_value("reg_rdata_o", reg_rdata_o, e_rdata);
    compare_value("ndmreset_ack_o pulses", 32'(ack_count), e_ack);
  endtask

  // Inputs hold still, so no acknowledge may show up here
  task automatic idle_gap();
    int gap;
    gap = int'($urandom % 4);
    for (int cyc = 0; cyc < gap; cyc++) begin
      @(negedge clk_i);
      #2;
      if (ndmreset_ack_o) begin
        other_errors++;
        $display("Acknowledge pulse in the idle gap after step %0d", steps_run);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int    fd;
    int    code;
    int    lines;
    string line;
    void'($urandom(94));
    value_errors         = 0;
    other_errors         = 0;
    steps_run            = 0;
    rst_ni               = 1'b0;
    rst_lc_ni            = 1'b0;
    // Active controls and requests during reset
    lc_hw_debug_en_i     = dm_gate_pkg::LcTxOn;
    lc_dft_en_i          = dm_gate_pkg::LcTxOn;
    otp_dis_late_debug_i = dm_gate_pkg::MuBi8False;
    reg_we_i             = 1'b0;
    reg_wdata_i          = '0;
    ndmreset_req_i       = 1'b1;
    debug_req_i          = '1;
    for (int i = 0; i < ResetCycles; i++) begin
      @(negedge clk_i);
    end
    check_reset_outputs();
    // Idle controls from the release edge on
    rst_ni           = 1'b1;
    rst_lc_ni        = 1'b1;
    lc_hw_debug_en_i = dm_gate_pkg::LcTxOff;
    lc_dft_en_i      = dm_gate_pkg::LcTxOff;
    ndmreset_req_i   = 1'b0;
    debug_req_i      = '0;
    fd = $fopen("testbench/dm_gate_golden.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open testbench/dm_gate_golden.txt");
    end else begin
      lines = 0;
      while (lines < MaxLines && !$feof(fd)) begin
        lines++;
        code = $fgets(line, fd);
        if (code == 0) break;
        // Blank lines and column notes
        if (line.len() < 2 || line.getc(0) == "#") continue;
        code = $sscanf(line, "%h %h %h %h %h %h %h %d %d %h %h %h %h %h %h %d",
                       f_we, f_wdata, f_hw, f_dft, f_otp, f_req, f_dbg, f_lc, f_hold,
                       e_fetch, e_rom, e_sba, e_dbg, e_ndm, e_rdata, e_ack);
        if (code != 16) begin
          other_errors++;
          $display("Golden line %0d has %0d fields instead of 16", lines, code);
        end else if (f_hold < 6 || f_hold > MaxHold) begin
          other_errors++;
          $display("Golden line %0d has a hold count outside 6 to %0d", lines, MaxHold);
        end else begin
          run_step();
          idle_gap();
        end
      end
      if (lines >= MaxLines && !$feof(fd)) begin
        other_errors++;
        $display("Golden file has more than %0d lines", MaxLines);
      end
      $fclose(fd);
      if (steps_run == 0) begin
        other_errors++;
        $display("Golden file held no steps");
      end
    end
    $display("Steps run: %0d, value errors: %0d, other errors: %0d",
             steps_run, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/dm_gate_golden.txt
# we wdata lc_hw_debug_en lc_dft_en otp_dis ndm_req debug_req lc_rst_cycles hold
#   exp_fetch exp_rom exp_sba exp_debug_req exp_ndm_req exp_rdata exp_ack_pulses
# lc_rst_cycles, hold and exp_ack_pulses are decimal, all other fields are hex
0 00000000 5 5 69 0 0 0 6   0 0 0 0 0 69696969 0
0 00000000 a 5 69 0 3 0 6   0 0 0 0 0 69696969 0
0 00000000 5 a 69 0 3 0 6   1 1 1 3 0 69696969 0
0 00000000 5 3 69 0 3 0 6   0 0 0 0 0 69696969 0
0 00000000 a f 69 0 3 0 6   0 0 0 0 0 69696969 0
0 00000000 a 5 96 0 1 0 6   1 1 1 1 0 69696969 0
0 00000000 e a 96 0 2 0 6   0 0 0 0 0 69696969 0
0 00000000 a 5 97 0 2 0 6   0 0 0 0 0 69696969 0
0 00000000 5 a 97 0 2 0 6   1 1 1 2 0 69696969 0
1 12345678 a 5 69 0 3 0 6   0 0 0 0 0 12345678 0
1 96969697 a 5 69 0 3 0 6   0 0 0 0 0 96969697 0
1 96969696 a 5 69 0 3 0 6   1 1 1 3 0 96969696 0
0 00000000 5 a 69 0 3 0 6   0 0 0 0 0 96969696 0
1 ffffffff 5 a 69 0 1 0 6   1 1 1 1 0 ffffffff 0
1 69696969 a 5 69 0 1 0 6   0 0 0 0 0 69696969 0
1 96969696 a 5 69 0 0 0 6   1 1 1 0 0 96969696 0
0 00000000 a 5 69 1 0 3 10  1 1 1 0 1 96969696 0
0 00000000 a 5 69 0 0 0 6   1 1 1 0 0 96969696 1
0 00000000 a 5 69 0 3 0 6   1 1 1 3 0 96969696 0
0 00000000 a 5 69 1 0 0 8   1 1 1 0 1 96969696 0
0 00000000 a 5 69 0 0 0 8   1 1 1 0 0 96969696 0
0 00000000 a 5 69 1 0 3 10  1 1 1 0 1 96969696 0
0 00000000 a 5 69 1 0 0 6   1 1 1 0 1 96969696 0
1 69696969 a 5 69 1 0 0 6   0 0 0 0 0 69696969 0
0 00000000 a 5 69 0 0 0 8   0 0 0 0 0 69696969 0
1 96969696 a 5 69 0 0 0 6   1 1 1 0 0 96969696 1
0 00000000 a 5 69 0 2 0 6   1 1 1 2 0 96969696 0
0 00000000 5 5 69 0 3 0 6   0 0 0 0 0 96969696 0

// File: tb.f
logic/dm_gate_pkg.sv
logic/dm_late_debug_regs.sv
logic/dm_lc_enable.sv
logic/dm_ndm_reset_tracker.sv
logic/dm_gate_top.sv
testbench/tb_dm_gate.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_dm_gate
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
